// File: filelist.f
verilog/led_ctrl_pkg.sv
verilog/cmd_dispatch.sv
verilog/pixel_write.sv
verilog/panel_blank.sv
verilog/led_ctrl_top.sv
sim/led_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LED panel decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module led_ctrl_tb \
    -Mdir obj_dir -o led_ctrl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/led_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0

// File: sim/led_ctrl_tb.sv
// ========================================
// Testbench for the LED panel command decoder
// directed tests against a frame memory model
// ========================================
`timescale 1ns/1ps

module led_ctrl_tb
    import led_ctrl_pkg::*;
;

    // blank sweep is RAM_DEPTH+2 cycles, the other ~22 bytes take at most 5 cycles each
    localparam int CYCLE_LIMIT = 12000;

    logic        clk_in;
    logic        reset;
    logic [7:0]  data_rx;
    logic        data_ready_n;
    logic [2:0]  rgb_enable;
    brightness_t brightness_enable;
    ram_wr_t     ram_wr;
    logic        busy;
    logic        ready_for_data;

    logic [7:0]  mem_model [RAM_DEPTH];
    logic [7:0]  snapshot [RAM_DEPTH];
    logic [11:0] wr_index;
    int          write_count;
    int          busy_cycles;
    int          ready_high_busy;
    int          cycle_count;
    logic        busy_seen;
    integer      seed = 32'h5d1a_243d;

    led_ctrl_top dut0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_wr            (ram_wr),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, DUT never finished", cycle_count);
            $display("TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // memory model and flag tracking, outputs are steady at the falling edge
    assign wr_index = ram_wr.addr;
    always @(negedge clk_in) begin
        if (ram_wr.we === 1'b1) begin
            mem_model[wr_index] = ram_wr.data;
            write_count = write_count + 1;
        end
        if (busy === 1'b1) begin
            busy_seen = 1'b1;
            busy_cycles = busy_cycles + 1;
            if (ready_for_data === 1'b1)
                ready_high_busy = ready_high_busy + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // layout row, col, byte_sel with the high byte at byte_sel 1
    function automatic int byte_index(input int row, input int col, input int sel);
        return (row * PANEL_WIDTH + col) * BYTES_PER_PIXEL + sel;
    endfunction

    task automatic send_byte(input logic [7:0] value);
        int gap;
        while (ready_for_data !== 1'b1)
            @(negedge clk_in);
        data_rx = value;
        data_ready_n = 1'b0;
        @(negedge clk_in);
        // strobe returns high between bytes
        data_ready_n = 1'b1;
        @(negedge clk_in);
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk_in);
    endtask

    task automatic wait_idle();
        while (busy !== 1'b0)
            @(negedge clk_in);
    endtask

    task automatic settings_test();
        busy_seen = 1'b0;
        send_byte(CMD_RED_OFF);
        send_byte(CMD_GREEN_OFF);
        send_byte(CMD_BLUE_ON);
        send_byte("q");
        check_value("rgb_enable", 32'(rgb_enable), 32'b100);
        check_value("busy", 32'(busy), 32'd0);
        check_value("busy_seen", 32'(busy_seen), 32'd0);
        send_byte(CMD_PLANES_OFF);
        send_byte(CMD_PLANE_FIRST);
        send_byte(CMD_PLANE_LAST);
        check_value("brightness_enable", 32'(brightness_enable), 32'b100001);
        send_byte(CMD_PLANES_ON);
        check_value("brightness_enable", 32'(brightness_enable), 32'h3f);
    endtask

    task automatic bright_load_test();
        send_byte(CMD_BRIGHT_LOAD);
        check_value("busy", 32'(busy), 32'd1);
        send_byte(8'h15);
        // busy drops the cycle after the argument byte
        check_value("brightness_enable", 32'(brightness_enable), 32'h15);
        check_value("busy", 32'(busy), 32'd0);
        // next byte must decode as a command again
        send_byte(CMD_RED_ON);
        check_value("rgb_enable", 32'(rgb_enable), 32'b101);
    endtask

    task automatic pixel_test(input int row, input int col, input logic [7:0] hi,
                              input logic [7:0] lo);
        int         writes_before;
        int         hi_idx;
        int         lo_idx;
        logic [7:0] expected;
        snapshot = mem_model;
        writes_before = write_count;
        hi_idx = byte_index(row, col, 1);
        lo_idx = byte_index(row, col, 0);
        send_byte(CMD_PIXEL);
        send_byte(8'(row));
        send_byte(8'(col));
        send_byte(hi);
        send_byte(lo);
        wait_idle();
        check_value("pixel write count", 32'(write_count - writes_before), 32'd2);
        for (int i = 0; i < RAM_DEPTH; i++) begin
            expected = (i == hi_idx) ? hi : (i == lo_idx) ? lo : snapshot[i];
            check_value($sformatf("mem_model[%0d]", i), 32'(mem_model[i]), 32'(expected));
        end
    endtask

    task automatic blank_test();
        int writes_before;
        writes_before = write_count;
        busy_cycles = 0;
        ready_high_busy = 0;
        send_byte(CMD_BLANK);
        wait_idle();
        check_value("blank write count", 32'(write_count - writes_before), 32'(RAM_DEPTH));
        check_value("blank busy cycles", 32'(busy_cycles), 32'(RAM_DEPTH + 1));
        check_value("ready_for_data high cycles", 32'(ready_high_busy), 32'd0);
        for (int i = 0; i < RAM_DEPTH; i++)
            check_value($sformatf("mem_model[%0d]", i), 32'(mem_model[i]), 32'd0);
    endtask

    initial begin
        logic [11:0] a;
        reset = 1'b1;
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        // nonzero fill so that a missed blank write shows up
        for (int i = 0; i < RAM_DEPTH; i++) begin
            a = 12'(i);
            mem_model[i] = 8'h80 | {1'b0, a[6:0] ^ a[11:5]};
        end
        repeat (8) @(negedge clk_in);
        reset = 1'b0;
        check_value("rgb_enable", 32'(rgb_enable), 32'b111);
        check_value("brightness_enable", 32'(brightness_enable), 32'h3f);
        check_value("busy", 32'(busy), 32'd0);
        check_value("ready_for_data", 32'(ready_for_data), 32'd1);
        @(negedge clk_in);
        check_value("write_count", 32'(write_count), 32'd0);

        settings_test();
        bright_load_test();
        pixel_test(3, 17, 8'ha5, 8'h3c);
        pixel_test($unsigned($random(seed)) % PANEL_HEIGHT,
                   $unsigned($random(seed)) % PANEL_WIDTH,
                   8'($random(seed)), 8'($random(seed)));
        blank_test();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog/led_ctrl_top.sv
// ======================================
// LED panel command decoder top level
// dispatcher plus the two memory writers
// ======================================
`timescale 1ns/1ps

module led_ctrl_top
    import led_ctrl_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic [7:0]  data_rx,
    input  logic        data_ready_n,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable,
    output ram_wr_t     ram_wr,
    output logic        busy,
    output logic        ready_for_data
);

    arg_t    pix_arg;
    logic    pix_done;
    logic    blank_start;
    logic    blank_done;
    ram_wr_t pix_wr;
    ram_wr_t blank_wr;

    cmd_dispatch u_dispatch (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_ready_n      (data_ready_n),
        .pix_done          (pix_done),
        .blank_done        (blank_done),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .pix_arg           (pix_arg),
        .blank_start       (blank_start),
        .busy              (busy),
        .ready_for_data    (ready_for_data)
    );

    pixel_write u_pixel_write (
        .clk_in   (clk_in),
        .reset    (reset),
        .pix_arg  (pix_arg),
        .pix_wr   (pix_wr),
        .pix_done (pix_done)
    );

    panel_blank u_panel_blank (
        .clk_in      (clk_in),
        .reset       (reset),
        .blank_start (blank_start),
        .blank_wr    (blank_wr),
        .blank_done  (blank_done)
    );

    // idle writer drives all zeros, so OR merges cleanly
    assign ram_wr = ram_wr_t'(pix_wr | blank_wr);

    // only one writer may be active in a cycle
    assert property (@(posedge clk_in) disable iff (reset)
        !(pix_wr.we && blank_wr.we))
        else $error("pixel and blank writers collided");

endmodule

// File: verilog/panel_blank.sv
// ======================================
// Panel blank
// sweeps the frame memory writing zeros
// ======================================
`timescale 1ns/1ps

module panel_blank
    import led_ctrl_pkg::*;
(
    input  logic    clk_in,
    input  logic    reset,
    input  logic    blank_start,
    output ram_wr_t blank_wr,
    output logic    blank_done
);

    logic                         active;
    logic [$bits(ram_addr_t)-1:0] sweep_addr;
    logic                         last_addr;

    assign last_addr = (sweep_addr == $bits(ram_addr_t)'(RAM_DEPTH - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active     <= 1'b0;
            sweep_addr <= '0;
        end else if (blank_start) begin
            active     <= 1'b1;
            sweep_addr <= '0;
        end else if (active) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (last_addr) begin
                active <= 1'b0;
            end
        end
    end

    assign blank_wr   = '{we: active, addr: ram_addr_t'(sweep_addr), data: 8'h00};
    assign blank_done = active && last_addr;

    assert property (@(posedge clk_in) disable iff (reset)
        blank_start |-> !active)
        else $error("blank restarted during a sweep");

endmodule

// File: verilog/pixel_write.sv
// ======================================
// Pixel writer
// four argument bytes to two memory writes
// ======================================
`timescale 1ns/1ps

module pixel_write
    import led_ctrl_pkg::*;
(
    input  logic    clk_in,
    input  logic    reset,
    input  arg_t    pix_arg,
    output ram_wr_t pix_wr,
    output logic    pix_done
);

    // 0 row, 1 column, 2 high byte, 3 low byte
    logic [1:0]          arg_cnt;
    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;
    logic                wr_we;
    ram_addr_t           wr_addr;
    logic [7:0]          wr_data;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_cnt  <= 2'd0;
            wr_we    <= 1'b0;
            pix_done <= 1'b0;
        end else begin
            wr_we    <= 1'b0;
            pix_done <= 1'b0;
            if (pix_arg.valid) begin
                arg_cnt <= arg_cnt + 2'd1;
                wr_we   <= arg_cnt[1];
                pix_done <= (arg_cnt == 2'd3);
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pix_arg.valid) begin
            case (arg_cnt)
                2'd0: row_q <= pix_arg.data[ROW_BITS-1:0];
                2'd1: col_q <= pix_arg.data[COL_BITS-1:0];
                default: begin
                    // high byte first, so byte_sel follows the count
                    wr_addr <= '{row: row_q, col: col_q, byte_sel: ~arg_cnt[0]};
                    wr_data <= pix_arg.data;
                end
            endcase
        end
    end

    // quiet writer drives zeros so the top can merge by OR
    always_comb begin
        pix_wr = '0;
        if (wr_we) begin
            pix_wr = '{we: 1'b1, addr: wr_addr, data: wr_data};
        end
    end

    assert property (@(posedge clk_in) disable iff (reset)
        pix_wr.we |=> !pix_wr.we)
        else $error("pixel writes in back-to-back cycles");

endmodule

// File: verilog/cmd_dispatch.sv
// ======================================
// Command dispatcher
// decodes strobed bytes, owns panel settings
// ======================================
`timescale 1ns/1ps

module cmd_dispatch
    import led_ctrl_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic [7:0]  data_rx,
    input  logic        data_ready_n,
    input  logic        pix_done,
    input  logic        blank_done,
    output logic [2:0]  rgb_enable,
    output brightness_t brightness_enable,
    output arg_t        pix_arg,
    output logic        blank_start,
    output logic        busy,
    output logic        ready_for_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRIGHT_LOAD,
        ST_PIXEL,
        ST_BLANK
    } cmd_state_t;

    cmd_state_t  state;
    logic        strobe;
    logic [7:0]  plane_num;
    brightness_t plane_mask;

    assign strobe = ~data_ready_n;

    // "1" hits the top plane, "6" the lowest
    assign plane_num  = data_rx - CMD_PLANE_FIRST;
    assign plane_mask = brightness_t'(1 << (BRIGHTNESS_LEVELS - 1)) >> plane_num;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= ST_IDLE;
            rgb_enable        <= 3'b111;
            brightness_enable <= '1;
            blank_start       <= 1'b0;
        end else begin
            blank_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (strobe) begin
                        case (data_rx) inside
                            CMD_RED_ON:    rgb_enable[0] <= 1'b1;
                            CMD_RED_OFF:   rgb_enable[0] <= 1'b0;
                            CMD_GREEN_ON:  rgb_enable[1] <= 1'b1;
                            CMD_GREEN_OFF: rgb_enable[1] <= 1'b0;
                            CMD_BLUE_ON:   rgb_enable[2] <= 1'b1;
                            CMD_BLUE_OFF:  rgb_enable[2] <= 1'b0;
                            [CMD_PLANE_FIRST:CMD_PLANE_LAST]: begin
                                brightness_enable <= brightness_enable ^ plane_mask;
                            end
                            CMD_PLANES_OFF:  brightness_enable <= '0;
                            CMD_PLANES_ON:   brightness_enable <= '1;
                            CMD_BRIGHT_LOAD: state <= ST_BRIGHT_LOAD;
                            CMD_PIXEL:       state <= ST_PIXEL;
                            CMD_BLANK: begin
                                state       <= ST_BLANK;
                                blank_start <= 1'b1;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                ST_BRIGHT_LOAD: begin
                    if (strobe) begin
                        brightness_enable <= data_rx[BRIGHTNESS_LEVELS-1:0];
                        state             <= ST_IDLE;
                    end
                end
                ST_PIXEL: begin
                    if (pix_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_BLANK: begin
                    if (blank_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // argument bytes go straight through to the pixel writer
    assign pix_arg = '{valid: (state == ST_PIXEL) && strobe, data: data_rx};

    assign busy           = (state != ST_IDLE);
    assign ready_for_data = (state != ST_BLANK);

    // sender honours back-pressure
    assert property (@(posedge clk_in) disable iff (reset)
        !ready_for_data |-> data_ready_n)
        else $error("byte strobed while not ready for data");

    assert property (@(posedge clk_in) disable iff (reset)
        blank_start |-> $past(state == ST_IDLE))
        else $error("blank started outside idle");

endmodule

// File: verilog/led_ctrl_pkg.sv
// ======================================
// LED panel command decoder definitions
// geometry, command codes, bus structs
// ======================================
package led_ctrl_pkg;

    // panel geometry
    localparam int PANEL_WIDTH       = 64;
    localparam int PANEL_HEIGHT      = 32;
    localparam int BYTES_PER_PIXEL   = 2;
    localparam int BRIGHTNESS_LEVELS = 6;
    localparam int ROW_BITS          = $clog2(PANEL_HEIGHT);
    localparam int COL_BITS          = $clog2(PANEL_WIDTH);
    localparam int RAM_DEPTH         = PANEL_WIDTH * PANEL_HEIGHT * BYTES_PER_PIXEL;

    // command bytes
    localparam logic [7:0] CMD_RED_ON      = "R";
    localparam logic [7:0] CMD_RED_OFF     = "r";
    localparam logic [7:0] CMD_GREEN_ON    = "G";
    localparam logic [7:0] CMD_GREEN_OFF   = "g";
    localparam logic [7:0] CMD_BLUE_ON     = "B";
    localparam logic [7:0] CMD_BLUE_OFF    = "b";
    localparam logic [7:0] CMD_PLANE_FIRST = "1";
    localparam logic [7:0] CMD_PLANE_LAST  = "6";
    localparam logic [7:0] CMD_PLANES_OFF  = "0";
    localparam logic [7:0] CMD_PLANES_ON   = "9";
    localparam logic [7:0] CMD_BRIGHT_LOAD = "T";
    localparam logic [7:0] CMD_PIXEL       = "P";
    localparam logic [7:0] CMD_BLANK       = "Z";

    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    // byte_sel 1 is the high byte of a pixel
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic                byte_sel;
    } ram_addr_t;

    typedef struct packed {
        logic      we;
        ram_addr_t addr;
        logic [7:0] data;
    } ram_wr_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } arg_t;

endpackage
